// ==== snake_config.svh ====
`ifndef SNAKE_CONFIG_SVH
`define SNAKE_CONFIG_SVH

// field size in cells, the outer ring of which is the border.
`define GRID_W 16
`define GRID_H 12

// number of snake segments, head included.
`define SNAKE_LEN 4

// head cell after reset; the body trails to the left of it.
`define START_X 8
`define START_Y 6

// apple cell after reset.
`define START_APPLE_X 3
`define START_APPLE_Y 3

`endif

// ==== grid_pkg.sv ====
package grid_pkg;

    // one cell coordinate, x or y.
    typedef logic [3:0] coord_t;

    // object codes as stored in the display memory.
    typedef enum logic [2:0] {
        blank      = 3'd0,
        snake_head = 3'd1,
        snake_body = 3'd2,
        apple_c    = 3'd3,
        border_c   = 3'd4
    } obj_code_t;

    typedef enum logic [1:0] {
        right,
        down,
        left,
        up
    } dir_t;

    // one changed cell as reported by the tracker.
    typedef struct packed {
        coord_t    x;
        coord_t    y;
        obj_code_t code;
    } cell_update_t;

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 8;

    // display address is y * GRID_W + x.
    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    typedef struct packed {
        logic ack;
    } wb_rsp_t;

endpackage

// ==== snake_state.sv ====
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_state (
    input  logic              clk,
    input  logic              nrst,
    input  grid_pkg::dir_t    dir,
    input  logic              step,
    input  logic              apple_load,
    input  grid_pkg::coord_t  apple_pos_x,
    input  grid_pkg::coord_t  apple_pos_y,
    input  grid_pkg::coord_t  cell_x,
    input  grid_pkg::coord_t  cell_y,
    output logic              body,
    output logic              head,
    output logic              apple,
    output logic              border,
    output logic              game_over
);

    import grid_pkg::*;

    localparam coord_t X_MAX = coord_t'(`GRID_W - 1);
    localparam coord_t Y_MAX = coord_t'(`GRID_H - 1);

    // segment 0 is the head, the last entry is the tail.
    coord_t seg_x [`SNAKE_LEN];
    coord_t seg_y [`SNAKE_LEN];
    coord_t apple_x;
    coord_t apple_y;
    coord_t next_x;
    coord_t next_y;
    logic   next_on_ring;

    always_comb begin
        next_x = seg_x[0];
        next_y = seg_y[0];
        case (dir)
            right:   next_x = seg_x[0] + 4'd1;
            down:    next_y = seg_y[0] + 4'd1;
            left:    next_x = seg_x[0] - 4'd1;
            default: next_y = seg_y[0] - 4'd1;
        endcase
    end

    assign next_on_ring = (next_x == '0) || (next_x == X_MAX) ||
                          (next_y == '0) || (next_y == Y_MAX);

    // a step into the ring freezes the snake for good.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `SNAKE_LEN; i++) begin
                seg_x[i] <= coord_t'(`START_X - i);
                seg_y[i] <= coord_t'(`START_Y);
            end
            game_over <= 1'b0;
        end else if (step && !game_over) begin
            if (next_on_ring) begin
                game_over <= 1'b1;
            end else begin
                seg_x[0] <= next_x;
                seg_y[0] <= next_y;
                for (int i = 1; i < `SNAKE_LEN; i++) begin
                    seg_x[i] <= seg_x[i-1];
                    seg_y[i] <= seg_y[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            apple_x <= coord_t'(`START_APPLE_X);
            apple_y <= coord_t'(`START_APPLE_Y);
        end else if (apple_load) begin
            apple_x <= apple_pos_x;
            apple_y <= apple_pos_y;
        end
    end

    // lookups for the cell the tracker is visiting.
    always_comb begin
        body = 1'b0;
        for (int i = 1; i < `SNAKE_LEN; i++) begin
            if (seg_x[i] == cell_x && seg_y[i] == cell_y) begin
                body = 1'b1;
            end
        end
    end

    assign head   = (seg_x[0] == cell_x) && (seg_y[0] == cell_y);
    assign apple  = (apple_x == cell_x) && (apple_y == cell_y);
    assign border = (cell_x == '0) || (cell_x == X_MAX) ||
                    (cell_y == '0) || (cell_y == Y_MAX);

endmodule

// ==== frame_tracker.sv ====
`timescale 1ns/1ps
`include "snake_config.svh"

module frame_tracker (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    body,
    input  logic                    head,
    input  logic                    apple,
    input  logic                    border,
    input  logic                    enable,
    output grid_pkg::coord_t        cell_x,
    output grid_pkg::coord_t        cell_y,
    output logic                    diff,
    output logic                    wrap,
    output grid_pkg::cell_update_t  update
);

    import grid_pkg::*;

    localparam coord_t X_MAX = coord_t'(`GRID_W - 1);
    localparam coord_t Y_MAX = coord_t'(`GRID_H - 1);

    // what the display memory holds after all reported writes.
    obj_code_t shadow [`GRID_W][`GRID_H];
    obj_code_t cur_code;
    obj_code_t want;
    logic      on_ring;
    logic      at_last;
    logic      changed;

    assign cur_code = shadow[cell_x][cell_y];
    assign on_ring  = (cell_x == '0) || (cell_x == X_MAX) ||
                      (cell_y == '0) || (cell_y == Y_MAX);
    assign at_last  = (cell_x == X_MAX) && (cell_y == Y_MAX);

    // ring cells only ever turn into border; inside, body wins over head.
    always_comb begin
        if (on_ring) begin
            want = border ? border_c : cur_code;
        end else if (body) begin
            want = snake_body;
        end else if (head) begin
            want = snake_head;
        end else if (apple) begin
            want = apple_c;
        end else begin
            want = blank;
        end
    end

    assign changed = (want != cur_code);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cell_x <= '0;
            cell_y <= '0;
            diff   <= 1'b0;
            wrap   <= 1'b0;
            for (int i = 0; i < `GRID_W; i++) begin
                for (int j = 0; j < `GRID_H; j++) begin
                    shadow[i][j] <= blank;
                end
            end
        end else begin
            // diff and wrap are single-cycle pulses.
            diff <= enable && changed;
            wrap <= enable && at_last;
            if (enable) begin
                if (cell_x == X_MAX) begin
                    cell_x <= '0;
                    cell_y <= (cell_y == Y_MAX) ? coord_t'(0) : cell_y + 4'd1;
                end else begin
                    cell_x <= cell_x + 4'd1;
                end
                if (changed) begin
                    shadow[cell_x][cell_y] <= want;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable && changed) begin
            update <= '{x: cell_x, y: cell_y, code: want};
        end
    end

endmodule

// ==== diff_writer.sv ====
`timescale 1ns/1ps
`include "snake_config.svh"

module diff_writer (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    diff,
    input  grid_pkg::cell_update_t  update,
    output logic                    busy,
    output bus_pkg::wb_req_t        wb_req,
    input  bus_pkg::wb_rsp_t        wb_rsp
);

    import bus_pkg::*;

    typedef enum logic {
        idle,
        write
    } wr_state_t;

    wr_state_t state;
    wb_adr_t   adr_q;
    wb_dat_t   dat_q;
    logic      open;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (diff) state <= write;
                default: if (wb_rsp.ack) state <= idle;
            endcase
        end
    end

    // address and data are captured as the cycle opens.
    always_ff @(posedge clk) begin
        if (state == idle && diff) begin
            adr_q <= wb_adr_t'(update.y * `GRID_W + update.x);
            dat_q <= wb_dat_t'(update.code);
        end
    end

    assign open = (state == write);

    // the tracker must not move on while a change is pending or in flight.
    assign busy = diff || open;

    assign wb_req = '{cyc: open, stb: open, we: 1'b1, adr: adr_q, dat: dat_q};

endmodule

// ==== snake_top.sv ====
`timescale 1ns/1ps

module snake_top (
    input  logic               clk,
    input  logic               nrst,
    input  logic               scan,
    input  logic               step,
    input  logic               apple_load,
    input  grid_pkg::dir_t     dir,
    input  grid_pkg::coord_t   apple_pos_x,
    input  grid_pkg::coord_t   apple_pos_y,
    output bus_pkg::wb_req_t   wb_req,
    input  bus_pkg::wb_rsp_t   wb_rsp,
    output logic               wrap,
    output logic               game_over
);

    import grid_pkg::*;

    coord_t       cell_x;
    coord_t       cell_y;
    cell_update_t update;
    logic         body;
    logic         head;
    logic         apple;
    logic         border;
    logic         diff;
    logic         busy;
    logic         enable;

    // a slow bus slave stalls the sweep through busy.
    assign enable = scan && !busy;

    snake_state u_state (
        .clk(clk), .nrst(nrst), .dir(dir), .step(step), .apple_load(apple_load),
        .apple_pos_x(apple_pos_x), .apple_pos_y(apple_pos_y),
        .cell_x(cell_x), .cell_y(cell_y), .body(body), .head(head),
        .apple(apple), .border(border), .game_over(game_over)
    );

    frame_tracker u_tracker (
        .clk(clk), .nrst(nrst), .body(body), .head(head), .apple(apple),
        .border(border), .enable(enable), .cell_x(cell_x), .cell_y(cell_y),
        .diff(diff), .wrap(wrap), .update(update)
    );

    diff_writer u_writer (
        .clk(clk), .nrst(nrst), .diff(diff), .update(update), .busy(busy),
        .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

endmodule

// ==== tb_snake_top.sv ====
`timescale 1ns/1ps
`include "snake_config.svh"

module tb_snake_top;

    import grid_pkg::*;
    import bus_pkg::*;

    localparam int CELLS = `GRID_W * `GRID_H;
    localparam int WAIT_LIMIT = 4000;

    logic    clk = 1'b0;
    logic    nrst = 1'b0;
    logic    scan = 1'b0;
    logic    step = 1'b0;
    logic    apple_load = 1'b0;
    dir_t    dir = right;
    coord_t  apple_pos_x = '0;
    coord_t  apple_pos_y = '0;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    wrap;
    logic    game_over;

    // display memory starts out blank, like the tracker's own copy.
    wb_dat_t     mem [CELLS] = '{default: '0};
    logic        ack_q = 1'b0;
    logic        in_cycle = 1'b0;
    int          delay_left = 0;
    int          delay_total = 0;
    wb_adr_t     cur_adr;
    wb_dat_t     cur_dat;
    logic [15:0] lfsr = 16'd24278;
    int          n_writes = 0;
    int          bus_errors = 0;
    int          ref_x [`SNAKE_LEN];
    int          ref_y [`SNAKE_LEN];
    int          ref_ax = `START_APPLE_X;
    int          ref_ay = `START_APPLE_Y;
    logic        ref_over = 1'b0;
    int          n_pass = 0;
    int          n_fail = 0;
    logic        stop = 1'b0;

    assign wb_rsp = '{ack: ack_q};

    always #20 clk = ~clk;

    snake_top uut (
        .clk(clk), .nrst(nrst), .scan(scan), .step(step), .apple_load(apple_load),
        .dir(dir), .apple_pos_x(apple_pos_x), .apple_pos_y(apple_pos_y),
        .wb_req(wb_req), .wb_rsp(wb_rsp), .wrap(wrap), .game_over(game_over)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        repeat (2) begin
            d = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // slave side; each write is stored as its ack goes out.
    always @(posedge clk) begin
        #2;
        if (ack_q) begin
            ack_q = 1'b0;
            if (wb_req.cyc || wb_req.stb) begin
                $display("mismatch at %0t: cycle still open after ack", $time);
                bus_errors++;
            end
        end else if (in_cycle || wb_req.cyc || wb_req.stb) begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                cur_adr = wb_req.adr;
                cur_dat = wb_req.dat;
                n_writes++;
                draw_delay(delay_left);
                delay_total += delay_left;
                if (!wb_req.we || wb_req.adr >= CELLS) begin
                    $display("mismatch at %0t: write with we %0b to address %0d", $time,
                             wb_req.we, wb_req.adr);
                    bus_errors++;
                end
            end
            if (!(wb_req.cyc && wb_req.stb) || wb_req.adr != cur_adr ||
                wb_req.dat != cur_dat) begin
                $display("mismatch at %0t: bus request changed before ack", $time);
                bus_errors++;
            end
            if (delay_left == 0) begin
                ack_q = 1'b1;
                in_cycle = 1'b0;
                if (cur_adr < CELLS)
                    mem[cur_adr] = cur_dat;
            end else begin
                delay_left--;
            end
        end
    end

    // later assignments override earlier ones, so the lowest priority goes first.
    function automatic obj_code_t expected_code(input int x, input int y);
        obj_code_t code;
        code = blank;
        if (x == ref_ax && y == ref_ay)
            code = apple_c;
        if (x == ref_x[0] && y == ref_y[0])
            code = snake_head;
        for (int i = 1; i < `SNAKE_LEN; i++) begin
            if (x == ref_x[i] && y == ref_y[i])
                code = snake_body;
        end
        if (x == 0 || y == 0 || x == `GRID_W - 1 || y == `GRID_H - 1)
            code = border_c;
        return code;
    endfunction

    task automatic record_result(input string name, input logic ok);
        if (ok)
            n_pass++;
        else
            n_fail++;
        $display("test %0d %s: %s", n_pass + n_fail, name, ok ? "ok" : "failed");
    endtask

    task automatic step_snake(input dir_t d);
        int nx;
        int ny;
        nx = ref_x[0] + int'(d == right) - int'(d == left);
        ny = ref_y[0] + int'(d == down) - int'(d == up);
        if (!ref_over) begin
            if (nx == 0 || ny == 0 || nx == `GRID_W - 1 || ny == `GRID_H - 1) begin
                ref_over = 1'b1;
            end else begin
                for (int i = `SNAKE_LEN - 1; i > 0; i--) begin
                    ref_x[i] = ref_x[i-1];
                    ref_y[i] = ref_y[i-1];
                end
                ref_x[0] = nx;
                ref_y[0] = ny;
            end
        end
        dir = d;
        step = 1'b1;
        @(posedge clk);
        #2;
        step = 1'b0;
    endtask

    task automatic load_apple(input int x, input int y);
        ref_ax = x;
        ref_ay = y;
        apple_pos_x = coord_t'(x);
        apple_pos_y = coord_t'(y);
        apple_load = 1'b1;
        @(posedge clk);
        #2;
        apple_load = 1'b0;
    endtask

    // two wraps guarantee one full sweep after the last change.
    // each write between the wraps stalls the sweep for the diff cycle plus
    // the open cycles, which is two cycles plus the ack delay.
    task automatic wait_sweeps(output int writes, output int gap, output int stall);
        int seen;
        int idle;
        int n;
        int w0;
        int d0;
        writes = n_writes;
        seen = 0;
        idle = 0;
        n = 0;
        gap = 0;
        stall = 0;
        w0 = 0;
        d0 = 0;
        while ((seen < 2 || idle < 2) && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
            if (wrap) begin
                seen++;
                if (seen == 1) begin
                    gap = n;
                    w0 = n_writes;
                    d0 = delay_total;
                end else if (seen == 2) begin
                    gap = n - gap;
                    stall = 2 * (n_writes - w0) + delay_total - d0;
                end
            end
            idle = (seen >= 2 && !wb_req.cyc) ? idle + 1 : 0;
        end
        if (n >= WAIT_LIMIT) begin
            $display("timeout: the tracker did not finish two sweeps in %0d cycles", WAIT_LIMIT);
            stop = 1'b1;
        end
        writes = n_writes - writes;
    endtask

    task automatic compare_field();
        int        bad;
        obj_code_t want;
        bad = 0;
        for (int y = 0; y < `GRID_H; y++) begin
            for (int x = 0; x < `GRID_W; x++) begin
                want = expected_code(x, y);
                if (mem[y * `GRID_W + x] != wb_dat_t'(want)) begin
                    bad++;
                    if (bad <= 4)
                        $display("mismatch at %0t: cell (%0d,%0d) holds %0d, expected %0d",
                                 $time, x, y, mem[y * `GRID_W + x], want);
                end
            end
        end
        record_result("display field", bad == 0);
    endtask

    initial begin
        int              fd;
        int              got;
        int              a;
        int              b;
        int              writes;
        int              gap;
        int              stall;
        logic [8*16-1:0] word;
        logic [8*16-1:0] arg;
        logic [8*96-1:0] rest;
        for (int i = 0; i < `SNAKE_LEN; i++) begin
            ref_x[i] = `START_X - i;
            ref_y[i] = `START_Y;
        end
        writes = 0;
        gap = 0;
        stall = 0;
        word = '0;
        fd = $fopen("snake_trace.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open snake_trace.txt");
            stop = 1'b1;
        end
        repeat (16) @(posedge clk);
        #2;
        nrst = 1'b1;
        scan = 1'b1;
        while (!stop && $fscanf(fd, "%s", word) == 1) begin
            arg = '0;
            if (word == "#") begin
                got = $fgets(rest, fd);
            end else if (word == "settle") begin
                wait_sweeps(writes, gap, stall);
                if (!stop) begin
                    compare_field();
                    if (gap != CELLS + stall)
                        $display("mismatch at %0t: %0d cycles between wraps, expected %0d",
                                 $time, gap, CELLS + stall);
                    record_result("sweep length", gap == CELLS + stall);
                end
            end else if (word == "step") begin
                got = $fscanf(fd, "%s", arg);
                if (arg == "right")
                    step_snake(right);
                else if (arg == "down")
                    step_snake(down);
                else if (arg == "left")
                    step_snake(left);
                else if (arg == "up")
                    step_snake(up);
                else begin
                    $display("error: unknown direction in the trace");
                    stop = 1'b1;
                end
            end else if (word == "apple") begin
                got = $fscanf(fd, "%d %d", a, b);
                if (got != 2) begin
                    $display("error: the apple command needs two coordinates");
                    stop = 1'b1;
                end else begin
                    load_apple(a, b);
                end
            end else if (word == "check_over") begin
                got = $fscanf(fd, "%d", b);
                if (game_over !== b[0] || ref_over !== b[0])
                    $display("mismatch at %0t: game_over is %0b, model %0b, trace expects %0b",
                             $time, game_over, ref_over, b[0]);
                record_result("game over flag", game_over === b[0] && ref_over === b[0]);
            end else if (word == "check_writes") begin
                got = $fscanf(fd, "%d", b);
                if (writes != b)
                    $display("mismatch at %0t: %0d bus writes in the last settle, expected %0d",
                             $time, writes, b);
                record_result("bus writes", writes == b);
            end else begin
                $display("error: unknown command in the trace");
                stop = 1'b1;
            end
            word = '0;
        end
        record_result("bus protocol", bus_errors == 0 && n_writes > 0);
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (!stop && n_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== snake_trace.txt ====
# columns: command, then its arguments. step <right|down|left|up>, apple <x> <y>,
# settle (two sweeps, then a field compare), check_over <0|1>, check_writes <count>
settle
check_over 0
step up
step up
step right
step right
settle
step down
step down
step down
step left
settle
apple 12 8
settle
step down
step right
step right
step right
step right
step right
settle
check_over 0
step right
check_over 1
step right
settle
check_writes 0
check_over 1

// ==== list.f ====
+incdir+.
grid_pkg.sv
bus_pkg.sv
snake_state.sv
frame_tracker.sv
diff_writer.sv
snake_top.sv
tb_snake_top.sv

// ==== Bender.yml ====
package:
  name: snake_display

export_include_dirs:
  - .

sources:
  - files:
      - grid_pkg.sv
      - bus_pkg.sv
      - snake_state.sv
      - frame_tracker.sv
      - diff_writer.sv
      - snake_top.sv
  - target: test
    files:
      - tb_snake_top.sv
